// ==== list.f ====
rtl/acia_reg_pkg.sv
rtl/serial_frame_pkg.sv
rtl/acia_rx.sv
rtl/acia_tx.sv
rtl/acia.sv
testbench/acia_tb.sv

// ==== testbench/acia_tb.sv ====
// ==========================================================
// acia testbench at 16 clocks per bit; the serial model is 8N1 only
// ==========================================================
`timescale 1ns/1ps

module acia_tb;
	localparam int n_frames = 23;	// rx and tx frames over all tests
	localparam real wd_ns = n_frames * 10 * 16 * 40 * 3 + 10000.0;

	logic		clk;
	logic		rst;
	logic		cs;
	logic		we;
	logic		rs;
	logic		rx;
	logic [7:0]	din;
	logic [7:0]	dout;
	logic		tx;
	logic		irq;

	int			mism_cnt = 0;		// wrong values
	int			err_cnt = 0;		// missing frames, strobes, timeouts
	int			frames_seen = 0;	// frames taken by the compare process
	logic [31:0]	rng = 32'he777fb58;
	logic [7:0]	exp_q[$];			// bytes written, in send order
	bit			skip_q[$];			// frame cut short by master reset
	logic [7:0]	mon_byte;
	logic		mon_start;
	logic		mon_stop;
	event		frame_seen;
	logic		m_rxf = 1'b0;		// model flags
	logic		m_txe = 1'b1;
	logic		m_err = 1'b0;
	logic		m_rie = 1'b0;
	logic [1:0]	m_txc = 2'b00;

	acia #(.clk_freq(160), .sym_rate(10)) u_dut (
		.clk(clk), .rst(rst), .cs(cs), .we(we), .rs(rs), .rx(rx),
		.din(din), .dout(dout), .tx(tx), .irq(irq)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// {irq, status} from the model flags
	function automatic logic [8:0] expected_status(input logic rxf, input logic txe,
		input logic err, input logic rie, input logic [1:0] tx_ctrl);
		logic i;
		i = (rxf & rie) | ((tx_ctrl == 2'b01) & txe);
		return {i, i, 1'b0, err, err, 2'b00, txe, rxf};	// overrun mirrors framing
	endfunction

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp)
		else
		begin
			$display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
			mism_cnt++;
		end
	endtask

	task automatic bus_write(input logic r, input logic [7:0] d);
		@(posedge clk);
		cs <= 1'b1;
		we <= 1'b1;
		rs <= r;
		din <= d;
		@(posedge clk);
		cs <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic bus_read(input logic r, output logic [7:0] v);
		@(posedge clk);
		cs <= 1'b1;
		we <= 1'b0;
		rs <= r;
		@(posedge clk);	// dout loads here
		cs <= 1'b0;
		@(negedge clk);
		v = dout;
	endtask

	task automatic check_status();
		logic [7:0] v;
		logic [8:0] e;
		bus_read(1'b0, v);
		e = expected_status(m_rxf, m_txe, m_err, m_rie, m_txc);
		check_value("status", e[7:0], v);
		check_value("irq", {7'b0, e[8]}, {7'b0, irq});
	endtask

	task automatic write_ctrl(input logic [7:0] d);
		bus_write(1'b0, d);
		m_rie = d[7];
		m_txc = d[6:5];
		if (d[1:0] == 2'b11)	// master reset clears the serial flags
		begin
			m_txe = 1'b1;
			m_rxf = 1'b0;
			m_err = 1'b0;
		end
	endtask

	task automatic wait_flag(input int bit_pos, input string what);
		logic [7:0] v;
		int n;
		n = 0;
		v = 8'h00;
		while (!v[bit_pos] && n < 200)
		begin
			bus_read(1'b0, v);
			n++;
		end
		assert (v[bit_pos])
		else
		begin
			$display("ERROR t=%0t %s never set in status", $time, what);
			err_cnt++;
		end
	endtask

	task automatic send_byte(input logic [7:0] b, input bit skip);
		wait_flag(1, "txe");
		m_txe = 1'b1;
		bus_write(1'b1, b);
		exp_q.push_back(b);
		skip_q.push_back(skip);
		m_txe = 1'b0;
	endtask

	task automatic wait_frames(input int target);
		int n;
		n = 0;
		while (frames_seen < target && n < 400)
		begin
			@(posedge clk);
			n++;
		end
		assert (frames_seen >= target)
		else
		begin
			$display("ERROR t=%0t expected frame never appeared on tx", $time);
			err_cnt++;
		end
	endtask

	// one rx frame, lsb first, chosen stop level
	task automatic drive_frame(input logic [7:0] b, input logic stop);
		logic [9:0] bits;
		bits = {stop, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			rx <= bits[i];
			repeat (15) @(posedge clk);
		end
		@(posedge clk);
		rx <= 1'b1;	// back to idle
		repeat (4) @(posedge clk);
	endtask

	task automatic receive_check(input logic [7:0] b, input logic stop);
		logic [7:0] v;
		drive_frame(b, stop);
		wait_flag(0, "rxf");
		m_rxf = 1'b1;
		m_err = ~stop;
		check_status();
		bus_read(1'b1, v);
		check_value("rx data", b, v);
		m_rxf = 1'b0;
		check_status();
	endtask

	// tx monitor, samples mid-bit
	initial
	begin
		forever
		begin
			@(negedge tx);
			repeat (8) @(negedge clk);
			mon_start = tx;
			for (int i = 0; i < 8; i++)
			begin
				repeat (16) @(negedge clk);
				mon_byte[i] = tx;
			end
			repeat (16) @(negedge clk);
			mon_stop = tx;
			-> frame_seen;
		end
	end

	// compares each monitored frame with the bytes written
	initial
	begin
		forever
		begin
			@(frame_seen);
			assert (exp_q.size() > 0)
			else
			begin
				$display("ERROR t=%0t frame on tx with nothing written", $time);
				err_cnt++;
			end
			if (exp_q.size() > 0 && !skip_q[0])
			begin
				check_value("tx start bit", 8'h00, {7'b0, mon_start});
				check_value("tx data", exp_q[0], mon_byte);
				check_value("tx stop bit", 8'h01, {7'b0, mon_stop});
			end
			if (exp_q.size() > 0)
			begin
				void'(exp_q.pop_front());
				void'(skip_q.pop_front());
			end
			frames_seen++;
		end
	end

	initial
	begin
		#(wd_ns);
		$display("ERROR watchdog expired before the test sequence finished");
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		logic [7:0] v;
		rst = 1'b1;
		cs = 1'b0;
		we = 1'b0;
		rs = 1'b0;
		rx = 1'b1;
		din = 8'h00;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		// reset state
		@(negedge clk);
		check_value("tx", 8'h01, {7'b0, tx});
		check_value("irq", 8'h00, {7'b0, irq});
		check_status();
		bus_read(1'b1, v);
		check_value("rx data", 8'h00, v);
		// transmit, txe clear while the frame goes out
		for (int i = 0; i < 8; i++)
		begin
			rng = next_rand(rng);
			send_byte(rng[7:0], 1'b0);
			check_status();
		end
		wait_frames(8);
		wait_flag(1, "txe");	// last frame out
		m_txe = 1'b1;
		// receive, then framing error and recovery
		for (int i = 0; i < 8; i++)
		begin
			rng = next_rand(rng);
			receive_check(rng[7:0], 1'b1);
		end
		rng = next_rand(rng);
		receive_check(rng[7:0], 1'b0);
		rng = next_rand(rng);
		receive_check(rng[7:0], 1'b1);
		// rx interrupt, receive_check covers rise and fall
		write_ctrl(8'h80);
		rng = next_rand(rng);
		receive_check(rng[7:0], 1'b1);
		// tx interrupt follows txe
		write_ctrl(8'h20);
		check_status();
		rng = next_rand(rng);
		send_byte(rng[7:0], 1'b0);
		check_status();
		wait_flag(1, "txe");
		m_txe = 1'b1;
		check_status();
		wait_frames(9);
		// master reset mid-frame, with an unread rx byte pending
		rng = next_rand(rng);
		drive_frame(rng[7:0], 1'b1);
		wait_flag(0, "rxf");
		m_rxf = 1'b1;
		rng = next_rand(rng);
		send_byte(rng[7:0], 1'b1);
		repeat (60) @(posedge clk);
		write_ctrl(8'h03);
		repeat (2) @(posedge clk);
		for (int i = 0; i < 200; i++)
		begin
			@(negedge clk);
			assert (tx === 1'b1)
			else
			begin
				$display("ERROR t=%0t tx left idle while held in master reset", $time);
				err_cnt++;
			end
		end
		check_status();
		write_ctrl(8'h00);
		rng = next_rand(rng);
		send_byte(rng[7:0], 1'b0);
		wait_frames(11);
		assert (exp_q.size() == 0)
		else
		begin
			$display("ERROR %0d written bytes never sent on tx", exp_q.size());
			err_cnt++;
		end
		$display("summary: %0d mismatches, %0d other errors", mism_cnt, err_cnt);
		if (mism_cnt == 0 && err_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== rtl/acia.sv ====
// ==========================================================
// reduced 6850 ACIA, 8N1 only, rate set by clk_freq/sym_rate
// no back-pressure; software must poll txe before each send
// ==========================================================
`timescale 1ns/1ps

module acia #(
	parameter int clk_freq = 32768,	// system clock in Hz
	parameter int sym_rate = 2400	// bit rate
)
(
	input  logic		clk,	// system clock
	input  logic		rst,	// system reset
	input  logic		cs,		// chip select
	input  logic		we,		// write enable
	input  logic		rs,		// 0 ctrl/status, 1 data
	input  logic		rx,		// serial in
	input  logic [7:0]	din,	// bus write data
	output logic [7:0]	dout,	// bus read data, registered
	output logic		tx,		// serial out
	output logic		irq		// interrupt request, active high
);
	acia_reg_pkg::bus_word_u	din_word;		// din seen both ways
	acia_reg_pkg::ctrl_fields_t	ctrl_q;			// control register
	logic						ctrl_wr;		// control register write
	logic						tx_start;		// data register write
	logic						rd_data;		// data register read
	logic						serial_rst;		// rx/tx reset
	logic						tx_busy;
	logic						prev_tx_busy;	// for busy falling edge
	logic						txe;			// tx data empty
	logic						rxf;			// rx data full
	logic [7:0]					rx_dat;
	logic						rx_stb;
	logic						rx_err;
	logic [7:0]					status;

	assign din_word = din;

	// bus decode
	assign ctrl_wr = cs & we & ~rs;
	assign tx_start = cs & we & rs;
	assign rd_data = cs & ~we & rs;

	// control register, word_select kept but unused
	always_ff @(posedge clk)
	begin
		if (rst)
			ctrl_q <= '0;
		else if (ctrl_wr)
			ctrl_q <= din_word.ctrl;
	end

	// cds 11 holds the serial section in reset
	assign serial_rst = rst |
		(ctrl_q.counter_divide_select == acia_reg_pkg::cds_master_reset);

	// txe clears on send, sets once the frame is out
	always_ff @(posedge clk)
	begin
		if (serial_rst)
		begin
			txe <= 1'b1;
			prev_tx_busy <= 1'b0;
		end
		else
		begin
			prev_tx_busy <= tx_busy;
			if (tx_start)
				txe <= 1'b0;	// even if tx ignores it
			else if (prev_tx_busy & ~tx_busy)
				txe <= 1'b1;
		end
	end

	// rxf sets after each frame, clears on data read
	always_ff @(posedge clk)
	begin
		if (serial_rst)
			rxf <= 1'b0;
		else if (rx_stb)
			rxf <= 1'b1;
		else if (rd_data)
			rxf <= 1'b0;
	end

	// status byte
	always_comb
	begin
		status = 8'h00;
		status[acia_reg_pkg::stat_irq] = irq;
		status[acia_reg_pkg::stat_parity] = 1'b0;		// no parity
		status[acia_reg_pkg::stat_overrun] = rx_err;	// one error flag
		status[acia_reg_pkg::stat_framing] = rx_err;
		status[acia_reg_pkg::stat_cts_n] = 1'b0;		// no modem lines
		status[acia_reg_pkg::stat_dcd_n] = 1'b0;
		status[acia_reg_pkg::stat_txe] = txe;
		status[acia_reg_pkg::stat_rxf] = rxf;
	end

	// read mux, dout holds until next read
	always_ff @(posedge clk)
	begin
		if (rst)
			dout <= 8'h00;
		else if (cs & ~we)
			dout <= rs ? rx_dat : status;
	end

	// interrupt, combinational
	assign irq = (rxf & ctrl_q.receive_interrupt_enable) |
		((ctrl_q.tx_control == acia_reg_pkg::tx_ctrl_irq_en) & txe);

	acia_rx #(
		.clk_freq	(clk_freq),
		.sym_rate	(sym_rate)
	) u_rx (
		.clk		(clk),
		.rst		(serial_rst),
		.rx_serial	(rx),
		.rx_dat		(rx_dat),
		.rx_stb		(rx_stb),
		.rx_err		(rx_err)
	);

	acia_tx #(
		.clk_freq	(clk_freq),
		.sym_rate	(sym_rate)
	) u_tx (
		.clk		(clk),
		.rst		(serial_rst),
		.tx_dat		(din_word.data),	// same byte, data view
		.tx_start	(tx_start),
		.tx_serial	(tx),
		.tx_busy	(tx_busy)
	);

endmodule

// ==== rtl/acia_tx.sv ====
// ==========================================================
// 8N1 transmitter; tx_start while busy is dropped
// ==========================================================
`timescale 1ns/1ps

module acia_tx #(
	parameter int clk_freq = 32768,	// system clock in Hz
	parameter int sym_rate = 2400	// bit rate
)
(
	input  logic		clk,		// system clock
	input  logic		rst,		// serial section reset
	input  logic [7:0]	tx_dat,		// byte to send
	input  logic		tx_start,	// one cycle, send request
	output logic		tx_serial,	// line out, idles high
	output logic		tx_busy		// frame in progress
);
	localparam int sym_cnt = clk_freq / sym_rate;				// clocks per bit
	localparam int cnt_w = (sym_cnt > 1) ? $clog2(sym_cnt) : 1;
	localparam int idx_w = $clog2(serial_frame_pkg::data_bits);

	localparam logic [cnt_w-1:0] bit_last = cnt_w'(sym_cnt - 1);
	localparam logic [idx_w-1:0] idx_last = idx_w'(serial_frame_pkg::data_bits - 1);

	logic [serial_frame_pkg::state_w-1:0]	state;
	logic [cnt_w-1:0]				cnt;		// bit time down-counter
	logic [idx_w-1:0]				bit_idx;	// data bit on the line
	logic [7:0]						shreg;		// remaining data bits

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= serial_frame_pkg::st_idle;
			cnt <= '0;
			bit_idx <= '0;
			tx_serial <= 1'b1;
			tx_busy <= 1'b0;
		end
		else
		begin
			case (state)
				serial_frame_pkg::st_idle:
				begin
					if (tx_start)
					begin
						shreg <= tx_dat;
						tx_serial <= 1'b0;	// start bit
						tx_busy <= 1'b1;
						cnt <= bit_last;
						state <= serial_frame_pkg::st_start;
					end
				end
				serial_frame_pkg::st_start:
				begin
					if (cnt != '0)
						cnt <= cnt - 1'b1;
					else
					begin
						tx_serial <= shreg[0];	// first data bit
						shreg <= shreg >> 1;
						bit_idx <= '0;
						cnt <= bit_last;
						state <= serial_frame_pkg::st_data;
					end
				end
				serial_frame_pkg::st_data:
				begin
					if (cnt != '0)
						cnt <= cnt - 1'b1;
					else
					begin
						cnt <= bit_last;
						if (bit_idx == idx_last)
						begin
							tx_serial <= 1'b1;	// stop bit
							state <= serial_frame_pkg::st_stop;
						end
						else
						begin
							tx_serial <= shreg[0];
							shreg <= shreg >> 1;
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				default:	// stop bit
				begin
					if (cnt != '0)
						cnt <= cnt - 1'b1;
					else
					begin
						tx_busy <= 1'b0;	// frame done
						state <= serial_frame_pkg::st_idle;
					end
				end
			endcase
		end
	end

endmodule

// ==== rtl/acia_rx.sv ====
// ==========================================================
// 8N1 receiver; needs clk_freq/sym_rate >= 2, no oversampling vote
// ==========================================================
`timescale 1ns/1ps

module acia_rx #(
	parameter int clk_freq = 32768,	// system clock in Hz
	parameter int sym_rate = 2400	// bit rate
)
(
	input  logic		clk,		// system clock
	input  logic		rst,		// serial section reset
	input  logic		rx_serial,	// raw async line
	output logic [7:0]	rx_dat,		// last received byte
	output logic		rx_stb,		// one cycle, byte done
	output logic		rx_err		// stop bit was low
);
	localparam int sym_cnt = clk_freq / sym_rate;				// clocks per bit
	localparam int cnt_w = (sym_cnt > 1) ? $clog2(sym_cnt) : 1;
	localparam int idx_w = $clog2(serial_frame_pkg::data_bits);

	localparam logic [cnt_w-1:0] bit_last = cnt_w'(sym_cnt - 1);		// full bit
	localparam logic [cnt_w-1:0] half_last = cnt_w'(sym_cnt / 2 - 1);	// to mid-bit
	localparam logic [idx_w-1:0] idx_last = idx_w'(serial_frame_pkg::data_bits - 1);

	logic [1:0]						sync_q;		// 2-flop synchronizer
	logic							rx_prev;	// for edge detect
	logic [serial_frame_pkg::state_w-1:0]	state;
	logic [cnt_w-1:0]				cnt;		// mid-bit down-counter
	logic [idx_w-1:0]				bit_idx;	// data bit number
	logic [7:0]						shreg;		// incoming bits, lsb first
	logic							rx_s;		// synchronized line

	assign rx_s = sync_q[1];

	// synchronizer and previous sample, idle high
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sync_q <= 2'b11;
			rx_prev <= 1'b1;
		end
		else
		begin
			sync_q <= {sync_q[0], rx_serial};
			rx_prev <= rx_s;
		end
	end

	// bit engine
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= serial_frame_pkg::st_idle;
			cnt <= '0;
			bit_idx <= '0;
			rx_dat <= 8'h00;
			rx_stb <= 1'b0;
			rx_err <= 1'b0;
		end
		else
		begin
			rx_stb <= 1'b0;	// strobe is a single cycle
			case (state)
				serial_frame_pkg::st_idle:
				begin
					if (rx_prev & ~rx_s)	// falling edge = start
					begin
						cnt <= half_last;
						state <= serial_frame_pkg::st_start;
					end
				end
				serial_frame_pkg::st_start:
				begin
					if (cnt != '0)
						cnt <= cnt - 1'b1;
					else if (rx_s)	// glitch, back to idle
						state <= serial_frame_pkg::st_idle;
					else
					begin
						cnt <= bit_last;
						bit_idx <= '0;
						state <= serial_frame_pkg::st_data;
					end
				end
				serial_frame_pkg::st_data:
				begin
					if (cnt != '0)
						cnt <= cnt - 1'b1;
					else
					begin
						shreg <= {rx_s, shreg[7:1]};	// lsb arrives first
						cnt <= bit_last;
						if (bit_idx == idx_last)
							state <= serial_frame_pkg::st_stop;
						else
							bit_idx <= bit_idx + 1'b1;
					end
				end
				default:	// stop bit
				begin
					if (cnt != '0)
						cnt <= cnt - 1'b1;
					else
					begin
						rx_dat <= shreg;	// overwrites unread byte
						rx_err <= ~rx_s;	// framing check
						rx_stb <= 1'b1;
						state <= serial_frame_pkg::st_idle;
					end
				end
			endcase
		end
	end

endmodule

// ==== rtl/serial_frame_pkg.sv ====
// ==========================================================
// frame is fixed 8N1; state codes shared by both bit engines
// ==========================================================
package serial_frame_pkg;

	// data bits per frame, lsb first on the line
	localparam int data_bits = 8;

	// bit engine state encoding
	localparam int state_w = 2;

	localparam logic [state_w-1:0] st_idle	= 2'd0;	// line idle, waiting
	localparam logic [state_w-1:0] st_start	= 2'd1;	// start bit
	localparam logic [state_w-1:0] st_data	= 2'd2;	// data bits
	localparam logic [state_w-1:0] st_stop	= 2'd3;	// stop bit

endpackage

// ==== rtl/acia_reg_pkg.sv ====
// ==========================================================
// register map of the reduced 6850 ACIA; only rs selects a register
// word_select is stored in the control word but has no effect
// ==========================================================
package acia_reg_pkg;

	// control word, msb first as written on the bus
	typedef struct packed
	{
		logic		receive_interrupt_enable;	// bit 7
		logic [1:0]	tx_control;					// bits 6:5
		logic [2:0]	word_select;				// bits 4:2, kept only
		logic [1:0]	counter_divide_select;		// bits 1:0
	} ctrl_fields_t;

	// one bus byte, seen as control fields or as a tx data byte
	typedef union packed
	{
		ctrl_fields_t	ctrl;	// control register write
		logic [7:0]		data;	// transmit data write
	} bus_word_u;

	// counter divide select code that holds rx/tx in reset
	localparam logic [1:0] cds_master_reset = 2'b11;

	// tx control code that lets txe raise irq
	localparam logic [1:0] tx_ctrl_irq_en = 2'b01;

	// status byte bit positions
	localparam int stat_irq		= 7;	// irq pending
	localparam int stat_parity	= 6;	// never set, no parity
	localparam int stat_overrun	= 5;	// mirrors rx error
	localparam int stat_framing	= 4;	// rx error
	localparam int stat_cts_n	= 3;	// tied active
	localparam int stat_dcd_n	= 2;	// tied active
	localparam int stat_txe		= 1;	// tx data empty
	localparam int stat_rxf		= 0;	// rx data full

endpackage
